/* Bender.yml */
package:
  name: weight_loader

sources:
  - common/wload_pkg.sv
  - loader/burst_reader.sv
  - loader/beat_unpacker.sv
  - hdl/weight_bank.sv
  - hdl/weight_loader_top.sv
  - target: simulation
    files:
      - bench/axi_mem_model.sv
      - bench/tb_weight_loader.sv

/* bench/axi_mem_model.sv */
// Read-only memory slave model
`default_nettype none

module axi_mem_model (
    input  logic                          clk,
    input  logic                          rst_n,
    // Read address channel
    input  wload_pkg::ar_req_t            ar,
    input  logic                          arvalid,
    output logic                          arready,
    // Read data channel
    output wload_pkg::r_beat_t            r,
    output logic                          rvalid,
    input  logic                          rready,
    // Stall and error control from the testbench
    input  logic                          ar_hold,
    input  logic                          r_hold,
    input  logic                          err_en,
    input  logic [wload_pkg::ADDR_W-1:0]  err_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import wload_pkg::*;

    logic [ADDR_W-1:0] addr_q [8];  // Accepted bursts, oldest at rd_ptr
    logic [7:0]        len_q  [8];
    logic [2:0]        wr_ptr;
    logic [2:0]        rd_ptr;
    logic [7:0]        beat_idx;    // Beat within the current burst
    logic [ADDR_W-1:0] beat_addr;
    logic              is_last;

    assign arready   = !ar_hold;    // Pure stall, no queue limit
    assign beat_addr = addr_q[rd_ptr] + {beat_idx, 2'b00};
    assign is_last   = (beat_idx == len_q[rd_ptr]);

    always @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            beat_idx <= '0;
            rvalid   <= 1'b0;
            r        <= '0;
        end else begin
            if (arvalid && arready) begin
                addr_q[wr_ptr] <= ar.addr;
                len_q[wr_ptr]  <= ar.len;
                wr_ptr         <= wr_ptr + 1'b1;
            end
            // A presented beat holds until taken
            if (!rvalid || rready) begin
                if (rd_ptr != wr_ptr && !r_hold) begin
                    rvalid     <= 1'b1;
                    r.data.raw <= {~beat_addr[15:0], beat_addr[15:0]}; // Hi is inverse of lo
                    r.resp     <= (err_en && beat_addr == err_addr) ? 2'd2 : RESP_OKAY;
                    r.last     <= is_last;
                    if (is_last) begin
                        rd_ptr   <= rd_ptr + 1'b1;
                        beat_idx <= '0;
                    end else begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_weight_loader.sv */
// Weight loader testbench
`default_nettype none

module tb_weight_loader;
    timeunit 1ns;
    timeprecision 1ps;
    import wload_pkg::*;

    // ======================================================================
    // Configuration and signals
    // ======================================================================
    localparam int PE_COUNT  = 8;
    localparam int SPIKES    = 4;
    localparam int BURST_LEN = 4;
    localparam int WEIGHTS   = PE_COUNT * SPIKES;  // 16 beats, 4 bursts
    localparam int RD_W      = $clog2(WEIGHTS);

    logic              clk;
    logic              rst_n;
    logic              load_start;
    logic [ADDR_W-1:0] base_addr;
    logic              load_busy;
    logic              load_done;
    logic              load_error;
    ar_req_t           mem_ar;
    logic              mem_arvalid;
    logic              mem_arready;
    r_beat_t           mem_r;
    logic              mem_rvalid;
    logic              mem_rready;
    logic [RD_W-1:0]   rd_addr;
    weight_t           rd_data;

    logic              ar_hold;
    logic              r_hold;
    logic              stall_en;    // Random back-pressure on
    logic              err_en;
    logic [ADDR_W-1:0] err_addr;
    logic [15:0]       lfsr_state = 16'd17;

    int pass_count;
    int fail_count;
    int test_errors;                // Errors in the running test

    weight_loader_top #(
        .PE_COUNT  (PE_COUNT),
        .SPIKES    (SPIKES),
        .BURST_LEN (BURST_LEN)
    ) weight_loader_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_start  (load_start),
        .base_addr   (base_addr),
        .load_busy   (load_busy),
        .load_done   (load_done),
        .load_error  (load_error),
        .mem_ar      (mem_ar),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_r       (mem_r),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    axi_mem_model mem_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar       (mem_ar),
        .arvalid  (mem_arvalid),
        .arready  (mem_arready),
        .r        (mem_r),
        .rvalid   (mem_rvalid),
        .rready   (mem_rready),
        .ar_hold  (ar_hold),
        .r_hold   (r_hold),
        .err_en   (err_en),
        .err_addr (err_addr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;           // 10 ns period

    // 16-bit Galois LFSR, right shifting
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One step per stall bit
    always @(negedge clk) begin
        logic [15:0] s;
        if (stall_en) begin
            s = lfsr_next(lfsr_state);
            ar_hold <= s[0];
            s = lfsr_next(s);
            r_hold <= s[0];
            lfsr_state <= s;
        end else begin
            ar_hold <= 1'b0;
            r_hold  <= 1'b0;
        end
    end

    // Word at B + 4*(i/2), lo half for even i, inverted lo for odd i
    function automatic weight_t expected_weight(input logic [ADDR_W-1:0] base, input int idx);
        logic [ADDR_W-1:0] a;
        a = base + ADDR_W'(4 * (idx / 2));
        return (idx % 2 == 0) ? a[15:0] : ~a[15:0];
    endfunction

    // ======================================================================
    // Helper tasks
    // ======================================================================
    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic start_load(input logic [ADDR_W-1:0] base);
        @(negedge clk);
        base_addr  = base;
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
    endtask

    task automatic wait_done(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (!load_done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!load_done) begin
            $display("%s: timed out after %0d cycles waiting for load_done", name, limit);
            test_errors++;
        end else begin
            @(negedge clk);          // Bank flips at the end of the swap cycle
        end
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s: %s expected %h actual %h", name, what, expected, actual);
        test_errors++;
    endtask

    task automatic read_back(input string name, input logic [ADDR_W-1:0] base);
        weight_t exp;
        for (int i = 0; i < WEIGHTS; i++) begin
            rd_addr = RD_W'(i);
            @(negedge clk);          // One cycle read latency
            exp = expected_weight(base, i);
            if (rd_data !== exp) begin
                report_mismatch(name, $sformatf("weight %0d", i), exp, rd_data);
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic test_full_load();
        string name;
        name = "full_load";
        start_load(32'h1000);
        wait_done(name, 500);
        read_back(name, 32'h1000);
        if (load_error !== 1'b0) begin
            report_mismatch(name, "load_error", 32'd0, load_error);
        end
        finish_test(name);
    endtask

    task automatic test_random_stalls();
        string name;
        name = "random_stalls";
        stall_en = 1'b1;
        start_load(32'h2000);
        wait_done(name, 3000);
        stall_en = 1'b0;
        read_back(name, 32'h2000);
        finish_test(name);
    endtask

    task automatic test_double_buffer();
        string   name;
        weight_t exp;
        name = "double_buffer";
        start_load(32'h3000);
        // Active bank still holds the previous set
        for (int i = 0; i < 4; i++) begin
            rd_addr = RD_W'(i);
            @(negedge clk);
            if (!load_busy) begin
                $display("%s: load ended before the read-back during busy", name);
                test_errors++;
            end else begin
                exp = expected_weight(32'h2000, i);
                if (rd_data !== exp) begin
                    report_mismatch(name, $sformatf("old weight %0d", i), exp, rd_data);
                end
            end
        end
        wait_done(name, 500);
        read_back(name, 32'h3000);
        finish_test(name);
    endtask

    task automatic test_error_response();
        string name;
        name = "error_response";
        err_addr = 32'h4000 + 32'd20;  // Sixth beat
        err_en   = 1'b1;
        start_load(32'h4000);
        wait_done(name, 500);
        if (load_error !== 1'b1) begin
            report_mismatch(name, "load_error after bad beat", 32'd1, load_error);
        end
        if (load_done !== 1'b1) begin
            report_mismatch(name, "load_done after bad beat", 32'd1, load_done);
        end
        err_en = 1'b0;
        start_load(32'h5000);
        wait_done(name, 500);
        if (load_error !== 1'b0) begin
            report_mismatch(name, "load_error after clean load", 32'd0, load_error);
        end
        read_back(name, 32'h5000);
        finish_test(name);
    endtask

    task automatic test_start_while_busy();
        string name;
        name = "start_while_busy";
        start_load(32'h6000);
        repeat (3) @(negedge clk);
        if (!load_busy) begin
            $display("%s: load ended before the second start pulse", name);
            test_errors++;
        end
        start_load(32'h7000);         // Must be ignored
        wait_done(name, 500);
        // No second load may follow
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            if (load_busy || !load_done) begin
                $display("%s: second start pulse began another load", name);
                test_errors++;
                break;
            end
        end
        read_back(name, 32'h6000);
        finish_test(name);
    endtask

    task automatic test_reset_state();
        string name;
        name = "reset_state";
        reset_dut();
        if (load_busy !== 1'b0)   report_mismatch(name, "load_busy", 32'd0, load_busy);
        if (load_done !== 1'b0)   report_mismatch(name, "load_done", 32'd0, load_done);
        if (load_error !== 1'b0)  report_mismatch(name, "load_error", 32'd0, load_error);
        if (mem_arvalid !== 1'b0) report_mismatch(name, "mem_arvalid", 32'd0, mem_arvalid);
        if (mem_rready !== 1'b0)  report_mismatch(name, "mem_rready", 32'd0, mem_rready);
        finish_test(name);
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================
    initial begin
        rst_n       = 1'b0;
        load_start  = 1'b0;
        base_addr   = '0;
        rd_addr     = '0;
        ar_hold     = 1'b0;
        r_hold      = 1'b0;
        stall_en    = 1'b0;
        err_en      = 1'b0;
        err_addr    = '0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;

        reset_dut();
        test_full_load();
        test_random_stalls();
        test_double_buffer();
        test_error_response();
        test_start_while_busy();
        test_reset_state();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/wload_pkg.sv */
// Weight loader shared types
`default_nettype none

package wload_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int ADDR_W           = 32;                // External byte address
    localparam int DATA_W           = 32;                // Read beat
    localparam int WEIGHT_W         = 16;                // FP16
    localparam int WEIGHTS_PER_BEAT = DATA_W / WEIGHT_W; // Two halves per beat

    // Response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ======================================================================
    // Payload types
    // ======================================================================
    typedef logic [WEIGHT_W-1:0] weight_t; // Raw FP16 bits, never interpreted here

    // High half first in bit order, so lo sits at [15:0]
    typedef struct packed {
        weight_t hi;
        weight_t lo;
    } weight_pair_t;

    // Memory side sees raw, unpacker sees a pair
    typedef union packed {
        logic [DATA_W-1:0] raw;
        weight_pair_t      pair;
    } beat_u;

    // ======================================================================
    // Channel structs
    // ======================================================================
    // Read address request, always 4-byte INCR
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;  // Beats minus one
    } ar_req_t;

    // Read data beat
    typedef struct packed {
        beat_u      data;
        logic [1:0] resp;
        logic       last;   // Final beat of the burst
    } r_beat_t;

endpackage

`default_nettype wire

/* hdl/weight_bank.sv */
// Double-buffered weight bank
`default_nettype none

module weight_bank #(
    parameter int DEPTH = 2048  // Entries per bank
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wload_pkg::weight_t       wr_data,
    input  logic                     wr_en,
    input  logic                     swap,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output wload_pkg::weight_t       rd_data
);
    import wload_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================
    weight_t bank_a [DEPTH];  // Bank 0
    weight_t bank_b [DEPTH];  // Bank 1
    logic    active;          // Bank the PE array reads

    // Flip on load completion
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;  // Bank 0 after reset
        end else if (swap) begin
            active <= ~active;
        end
    end

    // Loader only ever fills the shadow bank
    always_ff @(posedge clk) begin
        if (wr_en && active) begin
            bank_a[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !active) begin
            bank_b[wr_addr] <= wr_data;
        end
    end

    // ======================================================================
    // PE read port
    // ======================================================================
    // One cycle latency, follows the flag
    always_ff @(posedge clk) begin
        if (active) begin
            rd_data <= bank_b[rd_addr];
        end else begin
            rd_data <= bank_a[rd_addr];
        end
    end

    // Last shadow write lands before the flip
    a_no_write_on_swap: assert property (@(posedge clk) disable iff (!rst_n)
        swap |-> !wr_en);

endmodule

`default_nettype wire

/* hdl/weight_loader_top.sv */
// Weight loader top level
`default_nettype none

module weight_loader_top #(
    parameter int PE_COUNT  = 128,
    parameter int SPIKES    = 16,
    parameter int BURST_LEN = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // Host control
    input  logic                                load_start,
    input  logic [wload_pkg::ADDR_W-1:0]        base_addr,
    output logic                                load_busy,
    output logic                                load_done,
    output logic                                load_error,
    // Memory read channels
    output wload_pkg::ar_req_t                  mem_ar,
    output logic                                mem_arvalid,
    input  logic                                mem_arready,
    input  wload_pkg::r_beat_t                  mem_r,
    input  logic                                mem_rvalid,
    output logic                                mem_rready,
    // PE array read port
    input  logic [$clog2(PE_COUNT*SPIKES)-1:0]  rd_addr,
    output wload_pkg::weight_t                  rd_data
);
    import wload_pkg::*;

    localparam int DEPTH = PE_COUNT * SPIKES;

    // ======================================================================
    // Internal nets
    // ======================================================================
    logic [$clog2(DEPTH)-1:0]   wr_addr;
    weight_t                    wr_data;
    logic                       wr_en;
    logic [$clog2(DEPTH+1)-1:0] weights_written;
    logic                       burst_retired;
    logic                       load_begin;
    logic                       swap;

    burst_reader #(
        .PE_COUNT  (PE_COUNT),
        .SPIKES    (SPIKES),
        .BURST_LEN (BURST_LEN)
    ) burst_reader_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_start      (load_start),
        .base_addr       (base_addr),
        .mem_ar          (mem_ar),
        .mem_arvalid     (mem_arvalid),
        .mem_arready     (mem_arready),
        .burst_retired   (burst_retired),
        .weights_written (weights_written),
        .load_busy       (load_busy),
        .load_done       (load_done),
        .load_begin      (load_begin),
        .swap            (swap)
    );

    beat_unpacker #(
        .DEPTH (DEPTH)
    ) beat_unpacker_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_begin      (load_begin),
        .mem_r           (mem_r),
        .mem_rvalid      (mem_rvalid),
        .mem_rready      (mem_rready),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .wr_en           (wr_en),
        .weights_written (weights_written),
        .burst_retired   (burst_retired),
        .load_error      (load_error)
    );

    weight_bank #(
        .DEPTH (DEPTH)
    ) weight_bank_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .swap    (swap),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* loader/beat_unpacker.sv */
// Read beat to weight write unpacker
`default_nettype none

module beat_unpacker #(
    parameter int DEPTH = 2048  // Weights per load
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             load_begin,
    input  wload_pkg::r_beat_t               mem_r,
    input  logic                             mem_rvalid,
    output logic                             mem_rready,
    output logic [$clog2(DEPTH)-1:0]         wr_addr,
    output wload_pkg::weight_t               wr_data,
    output logic                             wr_en,
    output logic [$clog2(DEPTH+1)-1:0]       weights_written,
    output logic                             burst_retired,
    output logic                             load_error
);
    import wload_pkg::*;

    localparam int AW = $clog2(DEPTH);

    beat_u held;       // Accepted beat, high half still owed
    logic  hold_full;  // High half goes out this cycle
    logic  accept;

    assign accept = mem_rvalid && mem_rready;

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rready      <= 1'b0;
            wr_en           <= 1'b0;
            hold_full       <= 1'b0;
            weights_written <= '0;
            burst_retired   <= 1'b0;
            load_error      <= 1'b0;
        end else begin
            wr_en         <= accept || hold_full;      // Lo after accept, hi after that
            hold_full     <= accept;
            mem_rready    <= !accept;                  // Low while the lo half is out
            burst_retired <= accept && mem_r.last;

            if (load_begin) begin
                weights_written <= '0;
            end else if (accept || hold_full) begin
                weights_written <= weights_written + 1'b1;
            end

            // Sticky across the load
            if (load_begin) begin
                load_error <= 1'b0;
            end else if (accept && mem_r.resp != RESP_OKAY) begin
                load_error <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Write payload
    // ======================================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            held    <= mem_r.data;
            wr_data <= mem_r.data.pair.lo;           // Low half first
            wr_addr <= weights_written[AW-1:0];
        end else if (hold_full) begin
            wr_data <= held.pair.hi;
            wr_addr <= weights_written[AW-1:0];      // Already stepped past lo
        end
    end

    // A high-half write is always preceded by its low half
    a_pair_order: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !hold_full |=> !(wr_en && !hold_full));

endmodule

`default_nettype wire

/* loader/burst_reader.sv */
// Burst read issue and load control
`default_nettype none

module burst_reader #(
    parameter int PE_COUNT  = 128,
    parameter int SPIKES    = 16,
    parameter int BURST_LEN = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  load_start,
    input  logic [wload_pkg::ADDR_W-1:0]          base_addr,
    output wload_pkg::ar_req_t                    mem_ar,
    output logic                                  mem_arvalid,
    input  logic                                  mem_arready,
    input  logic                                  burst_retired,
    input  logic [$clog2(PE_COUNT*SPIKES+1)-1:0]  weights_written,
    output logic                                  load_busy,
    output logic                                  load_done,
    output logic                                  load_begin,
    output logic                                  swap
);
    import wload_pkg::*;

    // ======================================================================
    // Load geometry
    // ======================================================================
    localparam int TOTAL_WEIGHTS = PE_COUNT * SPIKES;
    localparam int TOTAL_BEATS   = TOTAL_WEIGHTS / WEIGHTS_PER_BEAT;
    localparam int TOTAL_BURSTS  = (TOTAL_BEATS + BURST_LEN - 1) / BURST_LEN;
    localparam int LAST_LEN      = TOTAL_BEATS - (TOTAL_BURSTS - 1) * BURST_LEN; // Tail burst
    localparam int CNT_W         = $clog2(TOTAL_WEIGHTS + 1);
    localparam int BURST_W       = $clog2(TOTAL_BURSTS + 1);

    localparam logic [ADDR_W-1:0] BURST_STEP = ADDR_W'(BURST_LEN * (DATA_W / 8));
    localparam logic [7:0]        FULL_LEN   = 8'(BURST_LEN - 1);
    localparam logic [7:0]        TAIL_LEN   = 8'(LAST_LEN - 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1; // Requests still to send
    localparam logic [1:0] ST_DRAIN = 2'd2; // All sent, waiting on writes

    logic [1:0]         state;
    logic [BURST_W-1:0] issued;     // Bursts raised on AR so far
    logic [1:0]         out_cnt;    // Issued but not yet retired, pending AR included
    logic [1:0]         out_eff;    // Count after this cycle's retire
    logic [ADDR_W-1:0]  next_addr;  // Address of the next burst
    logic               ar_fire;
    logic               issue;      // Raise a new request this cycle
    logic               final_burst;

    assign ar_fire     = mem_arvalid && mem_arready;
    assign out_eff     = out_cnt - {1'b0, burst_retired};
    assign final_burst = (issued == BURST_W'(TOTAL_BURSTS - 1));

    // Slot free when AR idle or handing over, and window not full
    assign issue = (state == ST_ISSUE) && (issued != BURST_W'(TOTAL_BURSTS))
                && (!mem_arvalid || ar_fire) && (out_eff < 2'd2);

    // ======================================================================
    // Control FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            issued      <= '0;
            out_cnt     <= '0;
            mem_arvalid <= 1'b0;
            load_busy   <= 1'b0;
            load_done   <= 1'b0;
            load_begin  <= 1'b0;
            swap        <= 1'b0;
        end else begin
            load_begin <= 1'b0;                    // Pulses
            swap       <= 1'b0;
            out_cnt    <= out_eff + {1'b0, issue}; // Counted at issue, freed at retire
            case (state)
                ST_IDLE: begin
                    if (load_start) begin          // Only sampled while not busy
                        state      <= ST_ISSUE;
                        issued     <= '0;
                        load_busy  <= 1'b1;
                        load_done  <= 1'b0;
                        load_begin <= 1'b1;        // Clears unpacker count and error
                    end
                end
                ST_ISSUE: begin
                    if (issue) begin
                        mem_arvalid <= 1'b1;
                        issued      <= issued + 1'b1;
                    end else if (ar_fire) begin
                        mem_arvalid <= 1'b0;
                        if (issued == BURST_W'(TOTAL_BURSTS)) begin
                            state <= ST_DRAIN;     // Last request accepted
                        end
                    end
                end
                ST_DRAIN: begin
                    // Count already covers the write on the wire this cycle
                    if (weights_written == CNT_W'(TOTAL_WEIGHTS)) begin
                        state     <= ST_IDLE;
                        swap      <= 1'b1;
                        load_busy <= 1'b0;
                        load_done <= 1'b1;         // Held until next accepted start
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload, only moves when a new burst is raised
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && load_start) begin
            next_addr <= base_addr;
        end else if (issue) begin
            mem_ar.addr <= next_addr;
            mem_ar.len  <= final_burst ? TAIL_LEN : FULL_LEN;
            next_addr   <= next_addr + BURST_STEP;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> $stable(mem_ar));

    a_window: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= 2'd2);

endmodule

`default_nettype wire

/* weight_loader_top.f */
common/wload_pkg.sv
loader/burst_reader.sv
loader/beat_unpacker.sv
hdl/weight_bank.sv
hdl/weight_loader_top.sv
bench/axi_mem_model.sv
bench/tb_weight_loader.sv
